// File: logic/l2_types_pkg.sv
`default_nettype none

package l2_types_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Geometry
	////////////////////////////////////////////////////////////////////////////

	localparam int ADDR_BITS = 16;
	localparam int LINE_BITS = 128;
	localparam int OFFSET_BITS = 4;  // 16 bytes per line
	localparam int NUM_WAYS = 4;

	typedef logic [ADDR_BITS-1:0] l2_addr_t;
	typedef logic [LINE_BITS-1:0] l2_line_t;
	typedef logic [1:0] l2_way_t;
	typedef logic [7:0] l2_lru_t;  // [1:0] least recent, [7:6] most recent

	// Way 0 is evicted first out of reset
	localparam l2_lru_t LRU_RESET = {2'd3, 2'd2, 2'd1, 2'd0};

	typedef struct packed {
		logic write;
		l2_addr_t addr;
		l2_line_t wdata;
	} l2_req_t;

	typedef struct packed {
		logic write;
		l2_addr_t addr;  // Line aligned
		l2_line_t wdata;
	} l2_mem_req_t;

	typedef struct packed {
		logic load_line;    // Data, tag and valid
		logic load_dirty;
		logic dirty_val;
		logic load_lru;
		l2_way_t way_sel;
		logic fill_sel;     // 1 = line from memory
		logic wb_addr_sel;  // 1 = victim address
	} l2_ctrl_t;

	typedef struct packed {
		logic hit;
		l2_way_t hit_way;
		l2_way_t victim_way;
		logic victim_dirty;
	} l2_status_t;

endpackage

`default_nettype wire

// File: logic/l2_array.sv
`timescale 1ns/1ps
`default_nettype none

module l2_array #(
	parameter int width = 128,
	parameter int depth_bits = 5,
	parameter logic [width-1:0] reset_val = '0
) (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic write,
	input wire logic [depth_bits-1:0] index,
	input wire logic [width-1:0] datain,
	output logic [width-1:0] dataout
);

	logic [width-1:0] entries [2**depth_bits];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**depth_bits; i++) begin
				entries[i] <= reset_val;
			end
		end else if (write) begin
			entries[index] <= datain;
		end
	end

	assign dataout = entries[index];  // Combinational read

endmodule

`default_nettype wire

// File: logic/lru_stack.sv
`timescale 1ns/1ps
`default_nettype none

module lru_stack (
	input wire l2_types_pkg::l2_lru_t old_lru,
	input wire l2_types_pkg::l2_way_t way,
	output l2_types_pkg::l2_lru_t new_lru
);
	import l2_types_pkg::*;

	logic found;

	// Slot 0 holds the least recent way and slot NUM_WAYS-1 the most recent.
	// Once the touched way is found every slot above it moves down one,
	// which leaves the older ways where they were
	always_comb begin
		new_lru = old_lru;
		found = 1'b0;
		for (int i = 0; i < NUM_WAYS - 1; i++) begin
			if (old_lru[2*i +: 2] == way) begin
				found = 1'b1;
			end
			if (found) begin
				new_lru[2*i +: 2] = old_lru[2*(i+1) +: 2];
			end
		end
		new_lru[2*(NUM_WAYS-1) +: 2] = way;  // Now most recent
	end

endmodule

`default_nettype wire

// File: logic/l2_cache_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module l2_cache_datapath #(
	parameter int INDEX_BITS = 5
) (
	input wire logic clk,
	input wire logic rst_n,
	input wire l2_types_pkg::l2_req_t cur_req,
	input wire l2_types_pkg::l2_ctrl_t ctrl,
	input wire l2_types_pkg::l2_line_t mem_rdata,
	output l2_types_pkg::l2_status_t status,
	output l2_types_pkg::l2_line_t rdata,
	output l2_types_pkg::l2_addr_t mem_addr,
	output l2_types_pkg::l2_line_t mem_wdata
);
	import l2_types_pkg::*;

	localparam int TAG_BITS = ADDR_BITS - INDEX_BITS - OFFSET_BITS;

	logic [INDEX_BITS-1:0] index;
	logic [TAG_BITS-1:0] tag;
	l2_line_t fill_data;
	logic [NUM_WAYS-1:0] load_line_way;
	logic [NUM_WAYS-1:0] load_dirty_way;
	l2_line_t data_out [NUM_WAYS];
	logic [TAG_BITS-1:0] tag_out [NUM_WAYS];
	logic [NUM_WAYS-1:0] valid_out;
	logic [NUM_WAYS-1:0] dirty_out;
	logic [NUM_WAYS-1:0] way_hit;
	l2_way_t hit_way;
	l2_way_t victim_way;
	l2_lru_t lru_cur;
	l2_lru_t lru_next;

	assign index = cur_req.addr[OFFSET_BITS +: INDEX_BITS];
	assign tag = cur_req.addr[ADDR_BITS-1 -: TAG_BITS];

	assign fill_data = ctrl.fill_sel ? mem_rdata : cur_req.wdata;

	////////////////////////////////////////////////////////////////////////////
	// Per-way storage
	////////////////////////////////////////////////////////////////////////////

	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
		assign load_line_way[w] = ctrl.load_line && (ctrl.way_sel == l2_way_t'(w));
		assign load_dirty_way[w] = ctrl.load_dirty && (ctrl.way_sel == l2_way_t'(w));

		l2_array #(.width(LINE_BITS), .depth_bits(INDEX_BITS), .reset_val('0)) data_array (
			.clk,
			.rst_n,
			.write(load_line_way[w]),
			.index,
			.datain(fill_data),
			.dataout(data_out[w])
		);

		l2_array #(.width(TAG_BITS), .depth_bits(INDEX_BITS), .reset_val('0)) tag_array (
			.clk,
			.rst_n,
			.write(load_line_way[w]),
			.index,
			.datain(tag),
			.dataout(tag_out[w])
		);

		l2_array #(.width(1), .depth_bits(INDEX_BITS), .reset_val(1'b0)) valid_array (
			.clk,
			.rst_n,
			.write(load_line_way[w]),
			.index,
			.datain(1'b1),
			.dataout(valid_out[w])
		);

		l2_array #(.width(1), .depth_bits(INDEX_BITS), .reset_val(1'b0)) dirty_array (
			.clk,
			.rst_n,
			.write(load_dirty_way[w]),
			.index,
			.datain(ctrl.dirty_val),
			.dataout(dirty_out[w])
		);

		assign way_hit[w] = valid_out[w] && (tag_out[w] == tag);
	end

	l2_array #(.width($bits(l2_lru_t)), .depth_bits(INDEX_BITS), .reset_val(LRU_RESET)) lru_array (
		.clk,
		.rst_n,
		.write(ctrl.load_lru),
		.index,
		.datain(lru_next),
		.dataout(lru_cur)
	);

	lru_stack lru_update (
		.old_lru(lru_cur),
		.way(hit_way),
		.new_lru(lru_next)
	);

	////////////////////////////////////////////////////////////////////////////
	// Lookup and steering
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		hit_way = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (way_hit[w]) begin
				hit_way = l2_way_t'(w);
			end
		end
	end

	assign victim_way = lru_cur[1:0];  // Bottom of the stack

	assign status = '{
		hit: |way_hit,
		hit_way: hit_way,
		victim_way: victim_way,
		victim_dirty: valid_out[victim_way] && dirty_out[victim_way]
	};

	assign rdata = data_out[hit_way];
	assign mem_wdata = data_out[victim_way];

	// Writeback goes to the victim's own line, a fill to the request's line
	assign mem_addr = ctrl.wb_addr_sel ?
		{tag_out[victim_way], index, {OFFSET_BITS{1'b0}}} :
		{cur_req.addr[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

endmodule

`default_nettype wire

// File: logic/l2_cache_control.sv
`timescale 1ns/1ps
`default_nettype none

module l2_cache_control (
	input wire logic clk,
	input wire logic rst_n,

	input wire logic req_valid,
	output logic req_ready,
	input wire l2_types_pkg::l2_req_t req,
	output logic resp_valid,
	input wire logic resp_ready,

	output l2_types_pkg::l2_req_t cur_req,
	input wire l2_types_pkg::l2_status_t status,
	output l2_types_pkg::l2_ctrl_t ctrl,

	output logic mem_req_valid,
	input wire logic mem_req_ready,
	output logic mem_write,
	input wire logic mem_resp_valid
);

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		WRITEBACK,
		FILL,
		RESPOND
	} state_t;

	state_t state;
	state_t state_next;
	logic read_sent;  // Fill read accepted, waiting on data
	logic fill_done;

	assign req_ready = (state == IDLE);
	assign resp_valid = (state == RESPOND);
	assign fill_done = (state == FILL) && read_sent && mem_resp_valid;

	always_ff @(posedge clk) begin
		if (req_valid && req_ready) begin
			cur_req <= req;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			read_sent <= 1'b0;
		end else begin
			state <= state_next;
			if (fill_done) begin
				read_sent <= 1'b0;
			end else if (mem_req_valid && mem_req_ready && !mem_write) begin
				read_sent <= 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Next state and commands
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		ctrl = '0;
		mem_req_valid = 1'b0;
		mem_write = 1'b0;

		case (state)
			IDLE: begin
				if (req_valid) begin
					state_next = LOOKUP;
				end
			end

			LOOKUP: begin
				if (status.hit) begin
					ctrl.load_lru = 1'b1;
					ctrl.way_sel = status.hit_way;
					if (cur_req.write) begin  // Line-wide write, mark dirty
						ctrl.load_line = 1'b1;
						ctrl.load_dirty = 1'b1;
						ctrl.dirty_val = 1'b1;
					end
					state_next = RESPOND;
				end else if (status.victim_dirty) begin
					state_next = WRITEBACK;
				end else begin
					state_next = FILL;
				end
			end

			WRITEBACK: begin
				mem_req_valid = 1'b1;
				mem_write = 1'b1;
				ctrl.wb_addr_sel = 1'b1;
				if (mem_req_ready) begin
					state_next = FILL;
				end
			end

			FILL: begin
				mem_req_valid = !read_sent;
				ctrl.way_sel = status.victim_way;
				ctrl.fill_sel = 1'b1;
				if (fill_done) begin
					ctrl.load_line = 1'b1;
					ctrl.load_dirty = 1'b1;  // Clean after fill
					state_next = LOOKUP;     // Replays as a hit
				end
			end

			RESPOND: begin
				if (resp_ready) begin
					state_next = IDLE;
				end
			end

			default: state_next = IDLE;
		endcase
	end

endmodule

`default_nettype wire

// File: logic/l2_cache.sv
`timescale 1ns/1ps
`default_nettype none

module l2_cache #(
	parameter int INDEX_BITS = 5
) (
	input wire logic clk,
	input wire logic rst_n,

	// L1 side
	input wire logic req_valid,
	output logic req_ready,
	input wire l2_types_pkg::l2_req_t req,
	output logic resp_valid,
	input wire logic resp_ready,
	output l2_types_pkg::l2_line_t resp_rdata,

	// Memory side
	output logic mem_req_valid,
	input wire logic mem_req_ready,
	output l2_types_pkg::l2_mem_req_t mem_req,
	input wire logic mem_resp_valid,
	input wire l2_types_pkg::l2_line_t mem_resp_rdata
);
	import l2_types_pkg::*;

	l2_req_t cur_req;
	l2_ctrl_t ctrl;
	l2_status_t status;
	logic mem_write;
	l2_addr_t mem_addr;
	l2_line_t mem_wdata;

	assign mem_req = '{write: mem_write, addr: mem_addr, wdata: mem_wdata};

	l2_cache_control control (
		.clk,
		.rst_n,
		.req_valid,
		.req_ready,
		.req,
		.resp_valid,
		.resp_ready,
		.cur_req,
		.status,
		.ctrl,
		.mem_req_valid,
		.mem_req_ready,
		.mem_write,
		.mem_resp_valid
	);

	l2_cache_datapath #(.INDEX_BITS(INDEX_BITS)) datapath (
		.clk,
		.rst_n,
		.cur_req,
		.ctrl,
		.mem_rdata(mem_resp_rdata),
		.status,
		.rdata(resp_rdata),
		.mem_addr,
		.mem_wdata
	);

endmodule

`default_nettype wire

// File: sim/l2_cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module l2_cache_tb;
	import l2_types_pkg::*;

	localparam int INDEX_BITS = 5;
	localparam int NUM_SETS = 2**INDEX_BITS;
	localparam int CYCLES_PER_OP = 200;

	logic clk;
	logic rst_n;
	logic req_valid;
	logic req_ready;
	l2_req_t req;
	logic resp_valid;
	logic resp_ready;
	l2_line_t resp_rdata;
	logic mem_req_valid;
	logic mem_req_ready;
	l2_mem_req_t mem_req;
	logic mem_resp_valid;
	l2_line_t mem_resp_rdata;

	logic [31:0] rng_state;
	int errors = 0;
	int cycle_count = 0;
	int cycle_limit = 0;
	int mem_xfers = 0;
	int read_wait = 0;
	l2_addr_t read_addr;
	string cur_name = "reset";

	l2_line_t mem [l2_addr_t];  // Lines written back so far

	// Stimulus from file
	bit op_write [$];
	string op_name [$];
	l2_addr_t op_addr [$];
	l2_line_t op_wdata [$];
	l2_line_t op_exp [$];

	// Reference cache, slot 0 least recent
	l2_addr_t m_addr [NUM_SETS][NUM_WAYS];
	l2_line_t m_data [NUM_SETS][NUM_WAYS];
	bit m_dirty [NUM_SETS][NUM_WAYS];
	int m_count [NUM_SETS];
	l2_addr_t wb_addr_q [$];
	l2_line_t wb_data_q [$];

	l2_cache #(.INDEX_BITS(INDEX_BITS)) dut (
		.clk,
		.rst_n,
		.req_valid,
		.req_ready,
		.req,
		.resp_valid,
		.resp_ready,
		.resp_rdata,
		.mem_req_valid,
		.mem_req_ready,
		.mem_req,
		.mem_resp_valid,
		.mem_resp_rdata
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	// Unwritten memory: every 16-bit word holds its own byte address
	function automatic l2_line_t memory_line(input l2_addr_t a);
		l2_addr_t base;
		l2_line_t line;
		base = {a[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
		if (mem.exists(base)) begin
			return mem[base];
		end
		for (int i = 0; i < 8; i++) begin
			line[16*i +: 16] = base + l2_addr_t'(2*i);
		end
		return line;
	endfunction

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		errors++;
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped");
	endtask

	task automatic model_access(input bit wr, input l2_addr_t a, input l2_line_t wd,
			output bit hit);
		int s;
		int slot;
		l2_addr_t base;
		l2_line_t d;
		bit dirty;
		base = {a[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
		s = int'(a[OFFSET_BITS +: INDEX_BITS]);
		slot = -1;
		for (int i = 0; i < m_count[s]; i++) begin
			if (m_addr[s][i] == base) begin
				slot = i;
			end
		end
		hit = (slot >= 0);
		if (!hit) begin
			slot = 0;  // Miss evicts the least recent line once the set is full
			d = memory_line(base);
			dirty = 1'b0;
			if (m_count[s] == NUM_WAYS && m_dirty[s][0]) begin
				wb_addr_q.push_back(m_addr[s][0]);
				wb_data_q.push_back(m_data[s][0]);
			end
		end else begin
			d = m_data[s][slot];
			dirty = m_dirty[s][slot];
		end
		if (hit || m_count[s] == NUM_WAYS) begin
			for (int i = slot; i < m_count[s] - 1; i++) begin
				m_addr[s][i] = m_addr[s][i+1];
				m_data[s][i] = m_data[s][i+1];
				m_dirty[s][i] = m_dirty[s][i+1];
			end
			m_count[s]--;
		end
		if (wr) begin
			d = wd;
			dirty = 1'b1;
		end
		m_addr[s][m_count[s]] = base;
		m_data[s][m_count[s]] = d;
		m_dirty[s][m_count[s]] = dirty;
		m_count[s]++;
	endtask

	task automatic run_op(input int k);
		bit hit;
		bit accepted;
		int cycles;
		int start_xfers;
		cur_name = op_name[k];
		model_access(op_write[k], op_addr[k], op_wdata[k], hit);
		start_xfers = mem_xfers;
		@(negedge clk);
		req_valid = 1'b1;
		req.write = op_write[k];
		req.addr = op_addr[k];
		req.wdata = op_wdata[k];
		while (!req_ready) begin
			@(negedge clk);
		end
		@(negedge clk);  // Accepted on the edge just passed
		req_valid = 1'b0;
		req = '0;
		cycles = 1;
		while (!resp_valid) begin
			@(negedge clk);
			cycles++;
		end
		if (hit) begin
			assert (cycles == 2) else
				stop_with_failure($sformatf("%s: hit answered after %0d cycles instead of 2",
					cur_name, cycles));
			assert (mem_xfers == start_xfers) else
				stop_with_failure($sformatf("%s: memory was accessed on a hit", cur_name));
		end
		accepted = 1'b0;
		while (!accepted) begin
			assert (resp_valid) else
				stop_with_failure($sformatf("%s: response withdrawn before it was accepted",
					cur_name));
			assert (resp_rdata == op_exp[k]) else
				stop_with_failure($sformatf("mismatch %s expected %h actual %h",
					cur_name, op_exp[k], resp_rdata));
			assert (!req_ready) else
				stop_with_failure($sformatf("%s: cache ready again with a response pending",
					cur_name));
			resp_ready = (next_rand() % 4) != 0;  // Random stall
			accepted = resp_ready;
			@(negedge clk);
		end
		resp_ready = 1'b0;
		assert (wb_addr_q.size() == 0) else
			stop_with_failure($sformatf("%s: expected writeback was never issued", cur_name));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Memory model
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		if (rst_n) begin
			mem_resp_valid = 1'b0;
			if (read_wait > 0) begin
				read_wait--;
				if (read_wait == 0) begin
					mem_resp_valid = 1'b1;
					mem_resp_rdata = memory_line(read_addr);
				end
			end
			mem_req_ready = (next_rand() % 3) != 0;
			if (mem_req_valid && mem_req_ready) begin  // Transfers on the next edge
				mem_xfers++;
				if (mem_req.write) begin
					assert (wb_addr_q.size() != 0) else
						stop_with_failure($sformatf("%s: unexpected memory write to %h",
							cur_name, mem_req.addr));
					assert (mem_req.addr == wb_addr_q[0]) else
						stop_with_failure($sformatf("mismatch %s expected %h actual %h",
							cur_name, wb_addr_q[0], mem_req.addr));
					assert (mem_req.wdata == wb_data_q[0]) else
						stop_with_failure($sformatf("mismatch %s expected %h actual %h",
							cur_name, wb_data_q[0], mem_req.wdata));
					void'(wb_addr_q.pop_front());
					void'(wb_data_q.pop_front());
					mem[mem_req.addr] = mem_req.wdata;
				end else begin
					read_addr = mem_req.addr;
					read_wait = 1 + int'(next_rand() % 4);
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count > cycle_limit) begin
			stop_with_failure($sformatf("timeout: run still busy after %0d cycles", cycle_count));
		end
	end

	initial begin
		string line;
		string op;
		string name;
		l2_addr_t a;
		l2_line_t wd;
		l2_line_t ex;
		int fd;
		int n;
		req_valid = 1'b0;
		req = '0;
		resp_ready = 1'b0;
		mem_req_ready = 1'b0;
		mem_resp_valid = 1'b0;
		mem_resp_rdata = '0;
		rst_n = 1'b0;
		rng_state = 32'h4f001103;
		for (int s = 0; s < NUM_SETS; s++) begin
			m_count[s] = 0;
		end

		fd = $fopen("sim/l2_stimulus.txt", "r");
		if (fd == 0) begin
			stop_with_failure("could not open the stimulus file sim/l2_stimulus.txt");
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 1 && line.getc(0) != 8'h23) begin  // Skip blanks and #
				n = $sscanf(line, "%s %s %h %h %h", op, name, a, wd, ex);
				if (n != 5) begin
					stop_with_failure($sformatf("bad stimulus line: %s", line));
				end
				op_write.push_back(op == "W");
				op_name.push_back(name);
				op_addr.push_back(a);
				op_wdata.push_back(wd);
				op_exp.push_back(ex);
			end
		end
		$fclose(fd);
		cycle_limit = op_name.size() * CYCLES_PER_OP + 20;

		repeat (10) @(negedge clk);
		rst_n = 1'b1;

		for (int k = 0; k < op_name.size(); k++) begin
			run_op(k);
		end

		if (errors == 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			$display("=== FAIL ===");
			$fatal(1, "checks failed");
		end
	end

endmodule

`default_nettype wire

// File: sim/l2_stimulus.txt
# op name addr wdata expected  (hex, op R=read W=write)
# set 5 lines sit at 0x0050 + n*0x0200
R cold_rd_a 0100 0 010e010c010a01080106010401020100
R cold_rd_b 1230 0 123e123c123a12381236123412321230
R hit_rd_a 0104 0 010e010c010a01080106010401020100
W wr_b 1230 aaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaa aaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaa
R rd_after_wr 1238 0 aaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaa
W ev_w0 0050 11111111111111111111111111111111 11111111111111111111111111111111
W ev_w1 0250 22222222222222222222222222222222 22222222222222222222222222222222
W ev_w2 0450 33333333333333333333333333333333 33333333333333333333333333333333
W ev_w3 0650 44444444444444444444444444444444 44444444444444444444444444444444
R ev_r4 0850 0 085e085c085a08580856085408520850
R ev_reload0 0050 0 11111111111111111111111111111111
R lru_t3 0650 0 44444444444444444444444444444444
R lru_t2 0450 0 33333333333333333333333333333333
W lru_w 0a50 55555555555555555555555555555555 55555555555555555555555555555555
R lru_t0 0050 0 11111111111111111111111111111111
R lru_miss 0c50 0 0c5e0c5c0c5a0c580c560c540c520c50
R lru_evicted 0250 0 22222222222222222222222222222222
R lru_reload3 0650 0 44444444444444444444444444444444
W wr_miss 3ff0 0123456789abcdeffedcba9876543210 0123456789abcdeffedcba9876543210
R rd_wr_miss 3ff4 0 0123456789abcdeffedcba9876543210
R cold_rd_c 7f00 0 7f0e7f0c7f0a7f087f067f047f027f00
R cold_rd_d fff0 0 fffefffcfffafff8fff6fff4fff2fff0
R hit_rd_c 7f0c 0 7f0e7f0c7f0a7f087f067f047f027f00

// File: sources.f
logic/l2_types_pkg.sv
logic/l2_array.sv
logic/lru_stack.sv
logic/l2_cache_datapath.sv
logic/l2_cache_control.sv
logic/l2_cache.sv
sim/l2_cache_tb.sv

// File: Makefile
# Verilator build for the L2 cache testbench

VERILATOR ?= verilator
TOP ?= l2_cache_tb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --binary --timing --assert -j $(JOBS)

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
